/* Bender.yml */
package:
  name: lsu

sources:
  - design/lsu_pkg.sv
  - design/lsu_request_align.sv
  - design/lsu_txn_tracker.sv
  - design/lsu_rdata_align.sv
  - design/lsu_top.sv
  - target: test
    files:
      - test/lsu_mem_model.sv
      - test/lsu_tb.sv

/* design/lsu_pkg.sv */
// Shared types for the load-store unit
// Little-endian byte lanes on a 32-bit data bus
// Size encoding follows the execute stage: 00 byte, 01 half, 10 word
package lsu_pkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  typedef logic [31:0] word_t;    // Data or address word
  typedef logic [3:0]  be_t;      // One bit per byte lane
  typedef logic [1:0]  offset_t;  // Byte offset within a word

  // Access size
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  ////////////////////////////////////////
  // Execute stage and bus structs
  ////////////////////////////////////////

  // Load or store as it sits in execute, held until ready_0_o
  typedef struct packed {
    word_t     operand_a;  // Base
    word_t     operand_b;  // Offset, added to the base
    logic      we;         // Store when set
    lsu_size_e size;
    logic      sext;       // Sign extend loaded byte or half
    word_t     wdata;      // Store data, not yet rotated
  } ex_req_t;

  // One bus transaction
  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata;  // Already rotated onto its byte lanes
  } bus_req_t;

  // Bus response, one per granted request, in order
  typedef struct packed {
    word_t rdata;
    logic  err;
  } bus_resp_t;

  // Control carried from execute into writeback
  typedef struct packed {
    lsu_size_e size;
    logic      sext;
    logic      we;
    offset_t   offset;  // Address offset of the original access
    logic      last;    // Low only for the first half of a split
  } wb_ctrl_t;

  // Counter width able to hold 0 .. max_out
  function automatic int CNT_W(input int max_out);
    return (max_out < 1) ? 1 : $clog2(max_out + 1);
  endfunction

endpackage

/* design/lsu_rdata_align.sv */
// Writeback side: response realignment, split join and extension
// Response data is combinational from bus_rvalid_i to rdata_1_o
// Result of a split load is valid on the pulse with last_1_o high
// Stores still pulse valid_1_o, rdata_1_o is then meaningless
`timescale 1ns/1ps

module lsu_rdata_align import lsu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ctrl_update_i,
  input  ex_req_t   ex_req_i,
  input  logic      split_i,
  input  logic      split_q_i,
  input  offset_t   addr_offset_i,
  input  logic      bus_rvalid_i,
  input  bus_resp_t bus_resp_i,
  output logic      valid_1_o,
  output logic      last_1_o,
  output word_t     rdata_1_o,
  output logic      err_1_o
);

  wb_ctrl_t    wb_q;
  word_t       rdata_q;      // Raw first word of a split load
  logic        wb_busy_q;    // Writeback holds an access awaiting its response
  logic        rdata_split;
  logic [63:0] rdata_full;
  logic [63:0] rdata_shift;  // Upper half unused

  ////////////////////////////////////////
  // Writeback control
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_q      <= '0;
      wb_busy_q <= 1'b0;
    end else begin
      if (ctrl_update_i) begin
        wb_q.size   <= ex_req_i.size;
        wb_q.sext   <= ex_req_i.sext;
        wb_q.we     <= ex_req_i.we;
        wb_q.offset <= addr_offset_i;
        wb_q.last   <= !split_i;  // First half of a split is not last
      end
      if (ctrl_update_i)     wb_busy_q <= 1'b1;
      else if (bus_rvalid_i) wb_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (bus_rvalid_i && !wb_q.we && !wb_q.last) begin
      rdata_q <= bus_resp_i.rdata;  // Low bytes of the result
    end
  end

  ////////////////////////////////////////
  // Join, realign, extend
  ////////////////////////////////////////

  assign rdata_split = ((wb_q.size == LSU_WORD) && (wb_q.offset != 2'b00)) ||
                       ((wb_q.size == LSU_HALF) && (wb_q.offset == 2'b11));

  // Unsplit accesses shift the word against a copy of itself
  assign rdata_full  = rdata_split ? {bus_resp_i.rdata, rdata_q}
                                   : {bus_resp_i.rdata, bus_resp_i.rdata};
  assign rdata_shift = rdata_full >> (8 * wb_q.offset);

  always_comb begin
    case (wb_q.size)
      LSU_BYTE: rdata_1_o = {{24{wb_q.sext && rdata_shift[7]}}, rdata_shift[7:0]};
      LSU_HALF: rdata_1_o = {{16{wb_q.sext && rdata_shift[15]}}, rdata_shift[15:0]};
      default:  rdata_1_o = rdata_shift[31:0];
    endcase
  end

  assign valid_1_o = bus_rvalid_i;                   // One pulse per response
  assign last_1_o  = wb_q.last;
  assign err_1_o   = bus_rvalid_i && bus_resp_i.err;

  // Execute completion must reach writeback before its response
  a_valid_wb_busy: assert property (@(posedge clk) disable iff (!rst_n)
    valid_1_o |-> wb_busy_q)
    else $error("response with no access in writeback");

  // Second half is still in execute when the first half answers
  a_first_half_split: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_rvalid_i && !wb_q.last) |-> split_q_i)
    else $error("first half response without second half pending");

endmodule

/* design/lsu_request_align.sv */
// Address, byte enable and write data generation for the data bus
// Misaligned words and halfwords at offset 3 go out as two halves
// Second half reuses the held execute operands
// The execute stage must hold ex_req_i until ready_0_o
`timescale 1ns/1ps

module lsu_request_align import lsu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  ex_req_t  ex_req_i,
  input  logic     valid_0_i,
  input  logic     ctrl_update_i,    // Execute phase done this cycle
  output bus_req_t bus_req_o,
  output logic     split_o,          // First half of a split access in execute
  output logic     split_q_o,        // Second half in execute
  output offset_t  addr_offset_o
);

  word_t   addr;       // Effective byte address
  offset_t offset;
  be_t     be;
  word_t   wdata_rot;
  logic    split_q;

  assign addr   = ex_req_i.operand_a + ex_req_i.operand_b;
  assign offset = addr[1:0];

  ////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////

  always_comb begin
    be = 4'b0000;
    case (ex_req_i.size)
      LSU_BYTE: be = 4'b0001 << offset;
      LSU_HALF: begin
        if (split_q) be = 4'b0001;            // Upper byte lands in the next word
        else         be = 4'b0011 << offset;  // Offset 3 keeps only lane 3
      end
      default: begin
        if (split_q) begin
          // Low lanes of the next word
          case (offset)
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            2'b11:   be = 4'b0111;
            default: be = 4'b0000;  // Aligned word never splits
          endcase
        end else begin
          be = 4'b1111 << offset;
        end
      end
    endcase
  end

  // Rotate left by the offset; both halves of a split use the same rotation
  always_comb begin
    case (offset)
      2'b01:   wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      2'b11:   wdata_rot = {ex_req_i.wdata[7:0],  ex_req_i.wdata[31:8]};
      default: wdata_rot = ex_req_i.wdata;
    endcase
  end

  ////////////////////////////////////////
  // Split detection and tracking
  ////////////////////////////////////////

  always_comb begin
    split_o = 1'b0;
    if (valid_0_i && !split_q) begin
      if (ex_req_i.size == LSU_WORD) split_o = (offset != 2'b00);
      if (ex_req_i.size == LSU_HALF) split_o = (offset == 2'b11);
    end
  end

  // Cleared when execute goes idle so a dropped split cannot leak
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_0_i) begin
      split_q <= 1'b0;
    end else if (ctrl_update_i) begin
      split_q <= split_o;  // Set after first half, cleared after second
    end
  end

  always_comb begin
    bus_req_o.addr  = split_q ? {addr[31:2] + 30'd1, 2'b00} : addr;  // Next word for half two
    bus_req_o.we    = ex_req_i.we;
    bus_req_o.be    = be;
    bus_req_o.wdata = wdata_rot;
  end

  assign split_q_o     = split_q;
  assign addr_offset_o = offset;

  // A new instruction always starts on its first half
  // Operands seen with split_q high still belong to the split instruction
  a_split_q_first: assert property (@(posedge clk) disable iff (!rst_n)
    (split_q && valid_0_i) |-> $stable(ex_req_i))
    else $error("split_q high on the first cycle of an instruction");

endmodule

/* design/lsu_top.sv */
// Load-store unit top level
// At most MAX_OUTSTANDING bus transactions, in practice two
// (one in writeback, one granted in execute)
// Bus responses cannot be stalled, issue is throttled instead
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic      clk,
  input  logic      rst_n,

  // Execute stage
  input  ex_req_t   ex_req_i,
  input  logic      valid_0_i,
  input  logic      ready_0_i,        // Writeback can take the instruction
  output logic      ready_0_o,
  output logic      lsu_split_0_o,
  output logic      lsu_first_op_0_o,
  output logic      lsu_last_op_0_o,

  // Data bus
  output logic      bus_valid_o,
  output bus_req_t  bus_req_o,
  input  logic      bus_gnt_i,
  input  logic      bus_rvalid_i,
  input  bus_resp_t bus_resp_i,

  // Writeback stage
  output logic      valid_1_o,
  output logic      last_1_o,
  output word_t     rdata_1_o,
  output logic      err_1_o,

  output logic      busy_o,
  output logic      interruptible_o
);

  logic    ctrl_update;  // Execute phase completes
  logic    split;
  logic    split_q;
  offset_t addr_offset;

  assign lsu_split_0_o    = split;
  assign lsu_first_op_0_o = !split_q;
  assign lsu_last_op_0_o  = !split;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  lsu_request_align u_request_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_req_i      (ex_req_i),
    .valid_0_i     (valid_0_i),
    .ctrl_update_i (ctrl_update),
    .bus_req_o     (bus_req_o),
    .split_o       (split),
    .split_q_o     (split_q),
    .addr_offset_o (addr_offset)
  );

  lsu_txn_tracker #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_txn_tracker (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_0_i       (valid_0_i),
    .ready_0_i       (ready_0_i),
    .split_i         (split),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_valid_o     (bus_valid_o),
    .ctrl_update_o   (ctrl_update),
    .ready_0_o       (ready_0_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_update_i (ctrl_update),
    .ex_req_i      (ex_req_i),
    .split_i       (split),
    .split_q_i     (split_q),
    .addr_offset_i (addr_offset),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_resp_i    (bus_resp_i),
    .valid_1_o     (valid_1_o),
    .last_1_o      (last_1_o),
    .rdata_1_o     (rdata_1_o),
    .err_1_o       (err_1_o)
  );

endmodule

/* design/lsu_txn_tracker.sv */
// Outstanding transaction count and execute handshake
// ready_0_i gates a new request and execute completion
// Once on the bus a request is held until granted
// Writeback holds one access; completion waits for its response
`timescale 1ns/1ps

module lsu_txn_tracker import lsu_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_0_i,
  input  logic ready_0_i,
  input  logic split_i,
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  output logic bus_valid_o,
  output logic ctrl_update_o,   // Execute completion pulse
  output logic ready_0_o,
  output logic busy_o,
  output logic interruptible_o
);

  localparam int            CW      = CNT_W(MAX_OUTSTANDING);
  localparam logic [CW-1:0] CNT_MAX = CW'(MAX_OUTSTANDING);

  logic [CW-1:0] cnt_q;     // Granted, no response yet
  logic [CW-1:0] cnt_d;
  logic [CW-1:0] wb_cnt;    // Of those, already completed into writeback
  logic          count_up;
  logic          count_down;
  logic          req_q;     // Request raised and still waiting for grant
  logic          gnt_q;     // Execute phase granted, not yet completed
  logic          granted;
  logic          wb_free;

  ////////////////////////////////////////
  // Issue and completion
  ////////////////////////////////////////

  // Once raised the request stays up, the count cannot grow meanwhile
  assign bus_valid_o = valid_0_i && !gnt_q &&
                       (req_q || (ready_0_i && (cnt_q < CNT_MAX)));

  assign count_up   = bus_valid_o && bus_gnt_i;
  assign count_down = bus_rvalid_i;
  assign granted    = count_up || gnt_q;

  // Writeback slot is free, or its response retires this cycle
  assign wb_cnt  = cnt_q - CW'(gnt_q);
  assign wb_free = (wb_cnt == '0) || ((wb_cnt == CW'(1)) && bus_rvalid_i);

  assign ctrl_update_o = valid_0_i && ready_0_i && granted && wb_free;
  assign ready_0_o     = valid_0_i ? (ctrl_update_o && !split_i) : ready_0_i;  // Hold over split

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q <= 1'b0;
      gnt_q <= 1'b0;
    end else begin
      req_q <= bus_valid_o && !bus_gnt_i;
      if (!valid_0_i || ctrl_update_o) gnt_q <= 1'b0;
      else if (count_up)               gnt_q <= 1'b1;  // Waiting on writeback
    end
  end

  ////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + CW'(1);
      2'b01:   cnt_d = cnt_q - CW'(1);
      default: cnt_d = cnt_q;  // Both or neither
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) cnt_q <= '0;
    else        cnt_q <= cnt_d;
  end

  assign busy_o          = (cnt_q != '0) || bus_valid_o;
  assign interruptible_o = !req_q && (cnt_q == '0);  // First request cycle may still be dropped

  a_cnt_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= CNT_MAX)
    else $error("outstanding count above limit");

  a_rvalid_no_txn: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != '0))
    else $error("response with nothing outstanding");

  a_valid_retract: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_valid_o && !bus_gnt_i) |=> bus_valid_o)
    else $error("bus request retracted before grant");

endmodule

/* list.f */
design/lsu_pkg.sv
design/lsu_request_align.sv
design/lsu_txn_tracker.sv
design/lsu_rdata_align.sv
design/lsu_top.sv
test/lsu_mem_model.sv
test/lsu_tb.sv

/* test/lsu_mem_model.sv */
// Bus memory model for the load-store unit testbench
// Byte addressed, wraps at MEM_BYTES; reads see all writes granted before them
// Grant and response delays are random up to the limits given on the ports
// Accesses inside the error window return err and leave the memory untouched
`timescale 1ns/1ps

module lsu_mem_model import lsu_pkg::*; #(
  parameter int    MEM_BYTES = 4096,
  parameter word_t ERR_BASE  = 32'h0000_0F00,
  parameter int    ERR_SIZE  = 16,
  parameter int    SEED      = 23
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      bus_valid_i,
  input  bus_req_t  bus_req_i,
  output logic      bus_gnt_o,
  output logic      bus_rvalid_o,
  output bus_resp_t bus_resp_o,
  input  int        max_gnt_dly_i,   // 0 grants at once
  input  int        max_rsp_dly_i    // 0 answers on the next cycle
);

  logic [7:0] mem [MEM_BYTES];
  bus_resp_t  resp_q[$];   // Pending responses, in grant order
  int         due_q[$];    // Earliest cycle for each response
  int         cyc;
  int         gnt_wait;    // Cycles of valid left before the next grant
  int         seed;

  function automatic int rand_upto(input int max);
    int unsigned r;
    r = $random(seed);
    return (max <= 0) ? 0 : int'(r % (max + 1));
  endfunction

  // Fill pattern mixes all twelve address bits
  initial begin
    seed = SEED;
    for (int i = 0; i < MEM_BYTES; i++) mem[i] = 8'((i * 13) ^ (i >> 8) ^ (i >> 3));
  end

  task automatic accept(input bus_req_t req);
    bus_resp_t rsp;
    word_t     base;
    base      = {req.addr[31:2], 2'b00};
    rsp.err   = (req.addr >= ERR_BASE) && (req.addr < ERR_BASE + ERR_SIZE);
    rsp.rdata = '0;
    for (int k = 0; k < 4; k++) begin
      if (!req.we) rsp.rdata[8*k +: 8] = mem[(base + k) % MEM_BYTES];
      else if (req.be[k] && !rsp.err) mem[(base + k) % MEM_BYTES] = req.wdata[8*k +: 8];
    end
    resp_q.push_back(rsp);
    due_q.push_back(cyc + 1 + rand_upto(max_rsp_dly_i));
  endtask

  ////////////////////////////////////////
  // Sample on the rising edge
  ////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_q.delete();
      due_q.delete();
      cyc      = 0;
      gnt_wait = 0;
    end else begin
      if (bus_rvalid_o) begin  // Head response taken this cycle
        void'(resp_q.pop_front());
        void'(due_q.pop_front());
      end
      if (bus_valid_i && bus_gnt_o) begin
        accept(bus_req_i);
        gnt_wait = rand_upto(max_gnt_dly_i);
      end else if (bus_valid_i && gnt_wait > 0) begin
        gnt_wait--;
      end
      cyc++;
    end
  end

  // Outputs change on the falling edge only
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_gnt_o    = 1'b0;
      bus_rvalid_o = 1'b0;
      bus_resp_o   = '0;
    end else begin
      bus_gnt_o = (gnt_wait == 0);
      if (resp_q.size() > 0 && due_q[0] <= cyc) begin
        bus_rvalid_o = 1'b1;
        bus_resp_o   = resp_q[0];
      end else begin
        bus_rvalid_o = 1'b0;
        bus_resp_o   = '0;
      end
    end
  end

endmodule

/* test/lsu_tb.sv */
// Directed testbench for the load-store unit
// Expected data comes from a byte-wise reference copy of the bus memory
// Addresses stay below 4 KB, the memory model wraps above that
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int    MEM_BYTES    = 4096;
  localparam word_t ERR_BASE     = 32'h0000_0F00;
  localparam int    ERR_SIZE     = 16;
  localparam int    NUM_ACCESSES = 39;
  localparam int    TIMEOUT      = NUM_ACCESSES * 20;  // Cycles, generous per access

  // One expected instruction result
  typedef struct packed {
    word_t data;
    logic  split;
    logic  load;
    logic  err;
  } exp_t;

  // One writeback pulse
  typedef struct packed {
    logic  last;
    word_t rdata;
    logic  err;
  } resp_t;

  logic      clk;
  logic      rst_n;
  ex_req_t   ex_req;
  logic      valid_0;
  logic      ready_0;
  logic      ready_0_o, lsu_split_0_o, lsu_first_op_0_o, lsu_last_op_0_o;
  logic      bus_valid_o, bus_gnt_i, bus_rvalid_i;
  bus_req_t  bus_req_o;
  bus_resp_t bus_resp_i;
  logic      valid_1_o, last_1_o, err_1_o;
  word_t     rdata_1_o;
  logic      busy_o, interruptible_o;
  int        max_gnt_dly;
  int        max_rsp_dly;

  logic [7:0] ref_mem [MEM_BYTES];
  exp_t       exp_q[$];
  resp_t      resp_q[$];
  int         seed = 23;
  int         errors, checks, tests, err_mark;
  int         out_cnt, max_out, gnt_count, cycles;

  lsu_top #(.MAX_OUTSTANDING(2)) DUT (
    .clk, .rst_n, .ex_req_i(ex_req), .valid_0_i(valid_0), .ready_0_i(ready_0),
    .ready_0_o, .lsu_split_0_o, .lsu_first_op_0_o, .lsu_last_op_0_o,
    .bus_valid_o, .bus_req_o, .bus_gnt_i, .bus_rvalid_i, .bus_resp_i,
    .valid_1_o, .last_1_o, .rdata_1_o, .err_1_o, .busy_o, .interruptible_o
  );

  lsu_mem_model #(.MEM_BYTES(MEM_BYTES), .ERR_BASE(ERR_BASE), .ERR_SIZE(ERR_SIZE),
                  .SEED(23)) u_mem (
    .clk, .rst_n, .bus_valid_i(bus_valid_o), .bus_req_i(bus_req_o),
    .bus_gnt_o(bus_gnt_i), .bus_rvalid_o(bus_rvalid_i), .bus_resp_o(bus_resp_i),
    .max_gnt_dly_i(max_gnt_dly), .max_rsp_dly_i(max_rsp_dly)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Bus and writeback monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (out_cnt != 0 && interruptible_o) report_error("interruptible_o high with access pending");
      if (bus_valid_o && bus_gnt_i) begin
        out_cnt++;
        gnt_count++;
      end
      if (bus_rvalid_i) out_cnt--;
      if (out_cnt > max_out) max_out = out_cnt;
      if (valid_1_o) resp_q.push_back('{last: last_1_o, rdata: rdata_1_o, err: err_1_o});
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare and report
  ////////////////////////////////////////

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) report_error($sformatf("%s: got %08h, expected %08h", what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) report_error($sformatf("%s: got %b, expected %b", what, got, exp));
  endtask

  task automatic check_size_log(input string what, input int got, input int exp);
    checks++;
    if (got != exp) report_error($sformatf("%s: counted %0d, expected %0d", what, got, exp));
  endtask

  task automatic close_test(input string name);
    tests++;
    if (errors == err_mark) $display("[test] %s: ok", name);
    else $display("[test] %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Little-endian bytes from the reference copy, then extension
  function automatic word_t load_value(input word_t addr, input lsu_size_e size,
                                       input logic sext);
    word_t v;
    int    n;
    n = (size == LSU_BYTE) ? 1 : (size == LSU_HALF) ? 2 : 4;
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = ref_mem[(addr + k) % MEM_BYTES];
    if (sext && n == 1) v = {{24{v[7]}}, v[7:0]};
    if (sext && n == 2) v = {{16{v[15]}}, v[15:0]};
    return v;
  endfunction

  task automatic drive_req(input logic we, input lsu_size_e size, input logic sext,
                           input word_t addr, input word_t wdata);
    @(negedge clk);
    ex_req.operand_a = {addr[31:4], 4'h0};   // Base plus offset
    ex_req.operand_b = {28'h0, addr[3:0]};
    ex_req.we        = we;
    ex_req.size      = size;
    ex_req.sext      = sext;
    ex_req.wdata     = wdata;
    valid_0          = 1'b1;
  endtask

  // Wait for the handshake, then record what the instruction must return
  task automatic accept_req();
    exp_t  e;
    word_t a;
    int    n;
    logic  saw_split;   // lsu_split_0_o seen before the handshake
    logic  saw_first;   // lsu_last_op_0_o low before the handshake
    saw_split = 1'b0;
    saw_first = 1'b0;
    @(posedge clk);
    while (!ready_0_o) begin
      if (lsu_split_0_o)    saw_split = 1'b1;
      if (!lsu_last_op_0_o) saw_first = 1'b1;
      @(posedge clk);
    end
    a       = ex_req.operand_a + ex_req.operand_b;
    n       = (ex_req.size == LSU_BYTE) ? 1 : (ex_req.size == LSU_HALF) ? 2 : 4;
    e.split = (ex_req.size == LSU_WORD && a[1:0] != 2'b00) ||
              (ex_req.size == LSU_HALF && a[1:0] == 2'b11);
    e.load  = !ex_req.we;
    e.err   = (a >= ERR_BASE) && (a < ERR_BASE + ERR_SIZE);
    e.data  = ex_req.we ? '0 : load_value(a, ex_req.size, ex_req.sext);
    check_bit("lsu_split_0_o before handshake", saw_split, e.split);
    check_bit("lsu_last_op_0_o low before handshake", saw_first, e.split);
    check_bit("lsu_first_op_0_o at handshake", lsu_first_op_0_o, !e.split);
    if (ex_req.we && !e.err) begin
      for (int k = 0; k < n; k++) ref_mem[(a + k) % MEM_BYTES] = ex_req.wdata[8*k +: 8];
    end
    exp_q.push_back(e);
  endtask

  task automatic send(input logic we, input lsu_size_e size, input logic sext,
                      input word_t addr, input word_t wdata);
    drive_req(we, size, sext, addr, wdata);
    accept_req();
  endtask

  // Drop valid, wait for every pulse and compare in order
  task automatic finish_batch(input string what);
    exp_t  e;
    resp_t r;
    int    need;
    @(negedge clk);
    valid_0 = 1'b0;
    need    = 0;
    foreach (exp_q[i]) need += exp_q[i].split ? 2 : 1;
    while (resp_q.size() < need) @(negedge clk);
    repeat (2) @(negedge clk);                     // Catch surplus pulses
    check_size_log({what, " pulses"}, resp_q.size(), need);
    while (exp_q.size() > 0 && resp_q.size() > 0) begin
      e = exp_q.pop_front();
      if (e.split) begin
        r = resp_q.pop_front();
        check_bit({what, " first half last_1_o"}, r.last, 1'b0);
      end
      if (resp_q.size() > 0) begin
        r = resp_q.pop_front();
        check_bit({what, " last_1_o"}, r.last, 1'b1);
        check_bit({what, " err_1_o"}, r.err, e.err);
        if (e.load && !e.err) check_word({what, " rdata_1_o"}, r.rdata, e.data);
      end
    end
    exp_q.delete();
    resp_q.delete();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_store_load();
    check_bit("busy_o after reset", busy_o, 1'b0);
    check_bit("interruptible_o after reset", interruptible_o, 1'b1);
    check_bit("bus_valid_o after reset", bus_valid_o, 1'b0);
    send(1'b1, LSU_WORD, 1'b0, 32'h0000_0100, 32'hCAFE_0123);
    send(1'b0, LSU_WORD, 1'b0, 32'h0000_0100, '0);
    finish_batch("aligned reload");
    close_test("reset state, aligned store and reload");
  endtask

  task automatic test_small_loads();
    // Lanes with and without the sign bit set
    send(1'b1, LSU_WORD, 1'b0, 32'h0000_0140, 32'h80F1_7F0E);
    send(1'b1, LSU_WORD, 1'b0, 32'h0000_0150, 32'h7A95_3C86);
    for (int s = 0; s < 2; s++) begin
      for (int o = 0; o < 4; o++) send(1'b0, LSU_BYTE, 1'(s), 32'h0000_0140 + 32'(o), '0);
      for (int o = 0; o < 3; o++) send(1'b0, LSU_HALF, 1'(s), 32'h0000_0150 + 32'(o), '0);
    end
    finish_batch("byte and half loads");
    close_test("byte and halfword loads");
  endtask

  task automatic test_split();
    int    g;
    word_t a;
    for (int k = 0; k < 4; k++) begin
      g = gnt_count;
      a = 32'h0000_0180 + 32'(k * 8) + ((k < 3) ? 32'(k + 1) : 32'd3);
      send(1'b0, (k < 3) ? LSU_WORD : LSU_HALF, 1'b1, a, '0);
      finish_batch("split load");
      check_size_log("split load grants", gnt_count - g, 2);
    end
    g = gnt_count;
    send(1'b1, LSU_WORD, 1'b0, 32'h0000_0201, 32'hA1B2_C3D4);
    send(1'b1, LSU_HALF, 1'b0, 32'h0000_0213, 32'h0000_5E6F);
    finish_batch("split stores");
    check_size_log("split store grants", gnt_count - g, 4);
    for (int w = 0; w < 4; w++) begin
      a = 32'h0000_0200 + ((w >= 2) ? 32'h10 : 32'h0) + 32'(4 * (w % 2));
      send(1'b0, LSU_WORD, 1'b0, a, '0);      // Neighbors must be untouched
    end
    finish_batch("split store readback");
    close_test("split accesses");
  endtask

  task automatic test_back_to_back();
    lsu_size_e size;
    word_t     a;
    logic      sext;
    max_gnt_dly = 3;
    max_rsp_dly = 4;
    max_out     = 0;
    for (int k = 0; k < 8; k++) begin
      size = lsu_size_e'(2'($unsigned($random(seed)) % 3));
      a    = 32'h0000_0400 + ($unsigned($random(seed)) % 256);
      sext = 1'($random(seed));
      send(1'b0, size, sext, a, '0);
    end
    finish_batch("random loads");
    check_bit("at most 2 outstanding", max_out <= 2, 1'b1);
    max_gnt_dly = 0;
    max_rsp_dly = 0;
    close_test("back-to-back loads with random delays");
  endtask

  task automatic test_bus_error();
    send(1'b0, LSU_WORD, 1'b0, ERR_BASE + 32'd4, '0);
    send(1'b0, LSU_WORD, 1'b0, 32'h0000_0300, '0);
    finish_batch("bus error");
    close_test("bus error response");
  endtask

  task automatic test_stall();
    drive_req(1'b0, LSU_HALF, 1'b1, 32'h0000_0342, '0);
    ready_0 = 1'b0;                               // Writeback not ready
    repeat (5) begin
      @(posedge clk);
      check_bit("ready_0_o while stalled", ready_0_o, 1'b0);
      check_bit("bus_valid_o while stalled", bus_valid_o, 1'b0);
    end
    @(negedge clk);
    ready_0 = 1'b1;
    accept_req();
    @(negedge clk);
    valid_0 = 1'b0;
    @(posedge clk);
    check_bit("interruptible_o with access outstanding", interruptible_o, 1'b0);
    check_bit("busy_o with access outstanding", busy_o, 1'b1);
    finish_batch("stalled load");
    close_test("writeback stall");
  endtask

  initial begin
    ex_req      = '0;
    valid_0     = 1'b0;
    ready_0     = 1'b1;
    rst_n       = 1'b0;
    max_gnt_dly = 0;
    max_rsp_dly = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < MEM_BYTES; i++) ref_mem[i] = u_mem.mem[i];
    test_reset_store_load();
    test_small_loads();
    test_split();
    test_back_to_back();
    test_bus_error();
    test_stall();
    $display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
